//--- verilog/fp_types_pkg.sv
package fp_types_pkg;

    ////////////////////////////////////////
    // fp32 format constants
    ////////////////////////////////////////

    // exponent and fraction field widths
    localparam int EXP_W    = 8;
    localparam int FRAC_W   = 23;
    // hidden bit + fraction + one guard bit
    localparam int MAN_W    = 25;
    // all-ones exponent, reserved for inf
    localparam int EXP_MAX  = 255;
    // issue to result valid, in cycles
    localparam int PIPE_LAT = 5;

    // one single-precision value
    typedef struct packed {
        logic              sign;
        logic [EXP_W-1:0]  exponent;
        logic [FRAC_W-1:0] fraction;
    } fp32_t;

    ////////////////////////////////////////
    // pipeline stage payloads
    ////////////////////////////////////////

    // exponent compare result
    typedef struct packed {
        // operand b has the larger exponent
        logic             swap;
        logic [EXP_W-1:0] larger_exp;
        // |exp_a - exp_b|
        logic [EXP_W-1:0] shift;
        logic             valid;
    } exp_diff_t;

    // operands lined up for the adder
    typedef struct packed {
        logic             [EXP_W-1:0] exp;
        logic             sign_big;
        logic             sign_small;
        logic [MAN_W-1:0] man_big;
        logic [MAN_W-1:0] man_small;
        logic             valid;
    } aligned_t;

endpackage

//--- verilog/apb_regs_pkg.sv
package apb_regs_pkg;

    // apb bus widths
    localparam int ADDR_W = 5;
    localparam int DATA_W = 32;

    // register map, byte offsets
    localparam logic [ADDR_W-1:0] OFS_OP_A   = 5'h00;
    localparam logic [ADDR_W-1:0] OFS_OP_B   = 5'h04;
    localparam logic [ADDR_W-1:0] OFS_CTRL   = 5'h08;
    localparam logic [ADDR_W-1:0] OFS_STATUS = 5'h0c;
    localparam logic [ADDR_W-1:0] OFS_RESULT = 5'h10;

    // ctrl and status bit positions
    localparam int CTRL_START = 0;
    localparam int CTRL_SUB   = 1;
    localparam int STAT_BUSY  = 0;
    localparam int STAT_DONE  = 1;

    // master to slave
    typedef struct packed {
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [ADDR_W-1:0] paddr;
        logic [DATA_W-1:0] pwdata;
    } apb_req_t;

    // slave to master
    typedef struct packed {
        logic [DATA_W-1:0] prdata;
        logic              pready;
        logic              pslverr;
    } apb_rsp_t;

endpackage

//--- verilog/exponent_diff.sv
module exponent_diff (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic                            valid_in,
    input  logic [fp_types_pkg::EXP_W-1:0]  exp_a,
    input  logic [fp_types_pkg::EXP_W-1:0]  exp_b,
    output fp_types_pkg::exp_diff_t         diff
);

    // 9-bit subtract, msb is the borrow
    logic [fp_types_pkg::EXP_W:0]   sub_full;

    // stage 1 state
    logic                           valid_s1;
    logic                           borrow_s1;
    logic [fp_types_pkg::EXP_W-1:0] value_s1;
    logic [fp_types_pkg::EXP_W-1:0] exp_max_s1;

    assign sub_full = {1'b0, exp_a} - {1'b0, exp_b};

    ////////////////////////////////////////
    // stage 1: subtract, pick larger
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_s1   <= 1'b0;
            borrow_s1  <= 1'b0;
            value_s1   <= '0;
            exp_max_s1 <= '0;
        end else begin
            valid_s1 <= valid_in;
            // hold when nothing new arrives
            if (valid_in) begin
                borrow_s1 <= sub_full[fp_types_pkg::EXP_W];
                value_s1  <= sub_full[fp_types_pkg::EXP_W-1:0];
                // borrow means b is bigger
                exp_max_s1 <= sub_full[fp_types_pkg::EXP_W] ? exp_b : exp_a;
            end
        end
    end

    ////////////////////////////////////////
    // stage 2: magnitude of difference
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            diff <= '0;
        end else begin
            diff.valid <= valid_s1;
            if (valid_s1) begin
                diff.swap       <= borrow_s1;
                diff.larger_exp <= exp_max_s1;
                // two's complement back to b - a
                diff.shift      <= borrow_s1 ? -value_s1 : value_s1;
            end
        end
    end

endmodule

//--- verilog/mantissa_align.sv
module mantissa_align (
    input  logic                      clk,
    input  logic                      rstn,
    input  fp_types_pkg::exp_diff_t   diff,
    input  fp_types_pkg::fp32_t       opnd_a,
    input  fp_types_pkg::fp32_t       opnd_b,
    output fp_types_pkg::aligned_t    aligned
);

    // operands after the swap
    fp_types_pkg::fp32_t              opnd_big;
    fp_types_pkg::fp32_t              opnd_sml;

    // mantissas with hidden bit and guard
    logic [fp_types_pkg::MAN_W-1:0]   man_big;
    logic [fp_types_pkg::MAN_W-1:0]   man_sml;
    logic [fp_types_pkg::MAN_W-1:0]   man_shifted;

    always_comb begin
        // larger exponent goes first
        opnd_big = diff.swap ? opnd_b : opnd_a;
        opnd_sml = diff.swap ? opnd_a : opnd_b;

        // zero exponent, denormals included, reads as zero
        if (opnd_big.exponent != '0) begin
            man_big = {1'b1, opnd_big.fraction, 1'b0};
        end else begin
            man_big = '0;
        end
        if (opnd_sml.exponent != '0) begin
            man_sml = {1'b1, opnd_sml.fraction, 1'b0};
        end else begin
            man_sml = '0;
        end

        // everything falls off past the guard bit
        if (diff.shift >= fp_types_pkg::MAN_W) begin
            man_shifted = '0;
        end else begin
            man_shifted = man_sml >> diff.shift;
        end
    end

    ////////////////////////////////////////
    // single register stage
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            aligned <= '0;
        end else begin
            aligned.valid <= diff.valid;
            if (diff.valid) begin
                aligned.exp        <= diff.larger_exp;
                aligned.sign_big   <= opnd_big.sign;
                aligned.sign_small <= opnd_sml.sign;
                aligned.man_big    <= man_big;
                aligned.man_small  <= man_shifted;
            end
        end
    end

endmodule

//--- verilog/mantissa_add_norm.sv
module mantissa_add_norm (
    input  logic                      clk,
    input  logic                      rstn,
    input  fp_types_pkg::aligned_t    aligned,
    output fp_types_pkg::fp32_t       res,
    output logic                      res_valid
);

    // leading zeros of a mantissa, caller handles all-zero
    function automatic logic [4:0] lead_zeros(input logic [fp_types_pkg::MAN_W-1:0] value);
        logic [4:0] count;
        logic       found;
        count = '0;
        found = 1'b0;
        for (int i = fp_types_pkg::MAN_W - 1; i >= 0; i--) begin
            if (!found && value[i]) begin
                count = 5'(fp_types_pkg::MAN_W - 1 - i);
                found = 1'b1;
            end
        end
        return count;
    endfunction

    // stage 1 combinational
    logic                                eff_sub;
    logic                                sign_c;
    logic [fp_types_pkg::MAN_W:0]        sum_c;

    // stage 1 registers, sum keeps the carry bit
    logic                                valid_s1;
    logic                                sign_s1;
    logic                                eff_sub_s1;
    logic [fp_types_pkg::EXP_W-1:0]      exp_s1;
    logic [fp_types_pkg::MAN_W:0]        sum_s1;

    // stage 2 combinational
    logic [4:0]                          lz;
    logic [fp_types_pkg::MAN_W-1:0]      man_n;
    logic signed [fp_types_pkg::EXP_W+1:0] exp_n;
    fp_types_pkg::fp32_t                 res_c;

    ////////////////////////////////////////
    // stage 1: signed magnitude add
    ////////////////////////////////////////
    always_comb begin
        eff_sub = aligned.sign_big ^ aligned.sign_small;
        if (!eff_sub) begin
            sum_c  = {1'b0, aligned.man_big} + {1'b0, aligned.man_small};
            sign_c = aligned.sign_big;
        end else if (aligned.man_big >= aligned.man_small) begin
            sum_c  = {1'b0, aligned.man_big - aligned.man_small};
            sign_c = aligned.sign_big;
        end else begin
            // equal exponents, b was bigger
            sum_c  = {1'b0, aligned.man_small - aligned.man_big};
            sign_c = aligned.sign_small;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_s1   <= 1'b0;
            sign_s1    <= 1'b0;
            eff_sub_s1 <= 1'b0;
            exp_s1     <= '0;
            sum_s1     <= '0;
        end else begin
            valid_s1 <= aligned.valid;
            if (aligned.valid) begin
                sign_s1    <= sign_c;
                eff_sub_s1 <= eff_sub;
                exp_s1     <= aligned.exp;
                sum_s1     <= sum_c;
            end
        end
    end

    ////////////////////////////////////////
    // stage 2: normalise and pack
    ////////////////////////////////////////
    always_comb begin
        lz = lead_zeros(sum_s1[fp_types_pkg::MAN_W-1:0]);
        if (sum_s1[fp_types_pkg::MAN_W]) begin
            // carry out, one step right
            man_n = sum_s1[fp_types_pkg::MAN_W:1];
            exp_n = $signed({2'b00, exp_s1}) + 10'sd1;
        end else begin
            man_n = sum_s1[fp_types_pkg::MAN_W-1:0] << lz;
            exp_n = $signed({2'b00, exp_s1}) - $signed({5'b00000, lz});
        end

        if (sum_s1 == '0) begin
            // cancellation gives +0, 0 + 0 keeps the sign
            res_c = '{sign: sign_s1 & ~eff_sub_s1, exponent: '0, fraction: '0};
        end else if (exp_n < 1) begin
            res_c = '{sign: sign_s1, exponent: '0, fraction: '0};
        end else if (exp_n >= fp_types_pkg::EXP_MAX) begin
            res_c = '{sign: sign_s1, exponent: '1, fraction: '0};
        end else begin
            // drop hidden bit, truncate guard
            res_c = '{sign: sign_s1,
                      exponent: exp_n[fp_types_pkg::EXP_W-1:0],
                      fraction: man_n[fp_types_pkg::MAN_W-2:1]};
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            res_valid <= 1'b0;
            res       <= '0;
        end else begin
            res_valid <= valid_s1;
            if (valid_s1) begin
                res <= res_c;
            end
        end
    end

endmodule

//--- verilog/fp_apb_regs.sv
module fp_apb_regs (
    input  logic                    clk,
    input  logic                    rstn,
    input  apb_regs_pkg::apb_req_t  req,
    output apb_regs_pkg::apb_rsp_t  rsp,
    output logic                    issue,
    output fp_types_pkg::fp32_t     op_a,
    output fp_types_pkg::fp32_t     op_b,
    input  fp_types_pkg::fp32_t     res,
    input  logic                    res_valid
);

    // software visible registers
    fp_types_pkg::fp32_t       op_a_q;
    fp_types_pkg::fp32_t       op_b_q;
    fp_types_pkg::fp32_t       result_q;
    logic                      sub_q;
    logic                      busy_q;
    logic                      done_q;

    // decode
    logic                      access;
    logic                      hit;
    logic                      read_only;
    logic                      err;
    logic                      wr_en;
    logic                      start;
    logic [31:0]               rd_data;

    ////////////////////////////////////////
    // address decode
    ////////////////////////////////////////
    always_comb begin
        hit       = 1'b1;
        read_only = 1'b0;
        rd_data   = '0;
        case (req.paddr)
            apb_regs_pkg::OFS_OP_A:   rd_data = op_a_q;
            apb_regs_pkg::OFS_OP_B:   rd_data = op_b_q;
            apb_regs_pkg::OFS_CTRL:   rd_data[apb_regs_pkg::CTRL_SUB] = sub_q;
            apb_regs_pkg::OFS_STATUS: begin
                read_only = 1'b1;
                rd_data[apb_regs_pkg::STAT_BUSY] = busy_q;
                rd_data[apb_regs_pkg::STAT_DONE] = done_q;
            end
            apb_regs_pkg::OFS_RESULT: begin
                read_only = 1'b1;
                rd_data   = result_q;
            end
            default:                  hit = 1'b0;
        endcase
    end

    // access phase only, zero wait states
    assign access = req.psel & req.penable;
    assign err    = access & (~hit | (req.pwrite & read_only));
    assign wr_en  = access & req.pwrite & ~err;
    // start while busy is dropped silently
    assign start  = wr_en & (req.paddr == apb_regs_pkg::OFS_CTRL)
                  & req.pwdata[apb_regs_pkg::CTRL_START] & ~busy_q;

    assign rsp.prdata  = (access & ~req.pwrite & hit) ? rd_data : '0;
    assign rsp.pready  = 1'b1;
    assign rsp.pslverr = err;

    ////////////////////////////////////////
    // register writes and status
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            op_a_q   <= '0;
            op_b_q   <= '0;
            sub_q    <= 1'b0;
            result_q <= '0;
            busy_q   <= 1'b0;
            done_q   <= 1'b0;
            issue    <= 1'b0;
            op_a     <= '0;
            op_b     <= '0;
        end else begin
            issue <= start;
            if (wr_en && req.paddr == apb_regs_pkg::OFS_OP_A) begin
                op_a_q <= req.pwdata;
            end
            if (wr_en && req.paddr == apb_regs_pkg::OFS_OP_B) begin
                op_b_q <= req.pwdata;
            end
            if (wr_en && req.paddr == apb_regs_pkg::OFS_CTRL) begin
                sub_q <= req.pwdata[apb_regs_pkg::CTRL_SUB];
            end
            // snapshot operands, held for the whole operation
            if (start) begin
                op_a      <= op_a_q;
                op_b      <= op_b_q;
                // subtract is add with b negated
                op_b.sign <= op_b_q.sign ^ req.pwdata[apb_regs_pkg::CTRL_SUB];
                busy_q    <= 1'b1;
                done_q    <= 1'b0;
            end
            if (res_valid) begin
                result_q <= res;
                busy_q   <= 1'b0;
                done_q   <= 1'b1;
            end
        end
    end

endmodule

//--- verilog/fp_add_top.sv
module fp_add_top (
    input  logic        clk,
    input  logic        rstn,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [4:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);

    // apb bundles
    apb_regs_pkg::apb_req_t   req;
    apb_regs_pkg::apb_rsp_t   rsp;

    // register block to pipeline
    logic                     issue;
    fp_types_pkg::fp32_t      op_a;
    fp_types_pkg::fp32_t      op_b;

    // pipeline stages
    fp_types_pkg::exp_diff_t  diff;
    fp_types_pkg::aligned_t   aligned;
    fp_types_pkg::fp32_t      res;
    logic                     res_valid;

    assign req = '{psel: psel, penable: penable, pwrite: pwrite,
                   paddr: paddr, pwdata: pwdata};
    assign prdata  = rsp.prdata;
    assign pready  = rsp.pready;
    assign pslverr = rsp.pslverr;

    ////////////////////////////////////////
    // register block
    ////////////////////////////////////////
    fp_apb_regs i_regs (
        .clk       (clk),
        .rstn      (rstn),
        .req       (req),
        .rsp       (rsp),
        .issue     (issue),
        .op_a      (op_a),
        .op_b      (op_b),
        .res       (res),
        .res_valid (res_valid)
    );

    ////////////////////////////////////////
    // adder pipeline, 2 + 1 + 2 cycles
    ////////////////////////////////////////
    exponent_diff i_exp_diff (
        .clk      (clk),
        .rstn     (rstn),
        .valid_in (issue),
        .exp_a    (op_a.exponent),
        .exp_b    (op_b.exponent),
        .diff     (diff)
    );

    // operands are held by the register block while busy
    mantissa_align i_align (
        .clk     (clk),
        .rstn    (rstn),
        .diff    (diff),
        .opnd_a  (op_a),
        .opnd_b  (op_b),
        .aligned (aligned)
    );

    mantissa_add_norm i_add_norm (
        .clk       (clk),
        .rstn      (rstn),
        .aligned   (aligned),
        .res       (res),
        .res_valid (res_valid)
    );

endmodule

//--- testbench/fp_add_properties.sv
module fp_add_properties (
    input logic       clk,
    input logic       rstn,
    input logic       psel,
    input logic       penable,
    input logic       pwrite,
    input logic [4:0] paddr,
    input logic       pslverr,
    input logic       issue,
    input logic       res_valid
);

    // offset outside the map, or a write to a read-only register
    logic bad_access;
    // assertion failures so far
    int   fail_count = 0;

    assign bad_access = !(paddr inside {apb_regs_pkg::OFS_OP_A, apb_regs_pkg::OFS_OP_B,
                                        apb_regs_pkg::OFS_CTRL, apb_regs_pkg::OFS_STATUS,
                                        apb_regs_pkg::OFS_RESULT})
                        || (pwrite && (paddr == apb_regs_pkg::OFS_STATUS
                                       || paddr == apb_regs_pkg::OFS_RESULT));

    ////////////////////////////////////////
    // apb phase order
    ////////////////////////////////////////

    // zero wait states, so access lasts one cycle after setup
    property p_access_after_setup;
        @(posedge clk) disable iff (!rstn)
        penable |-> psel && $past(psel) && !$past(penable);
    endproperty
    a_access_after_setup: assert property (p_access_after_setup)
        else begin
            $error("penable high without a setup phase before it");
            fail_count = fail_count + 1;
        end

    // slave error in the access phase of a bad access, never elsewhere
    property p_err_in_access;
        @(posedge clk) disable iff (!rstn)
        pslverr == (psel && penable && bad_access);
    endproperty
    a_err_in_access: assert property (p_err_in_access)
        else begin
            $error("pslverr does not match the access phase and the register map");
            fail_count = fail_count + 1;
        end

    ////////////////////////////////////////
    // pipeline latency
    ////////////////////////////////////////
    a_issue_to_result: assert property (@(posedge clk) disable iff (!rstn)
        issue |-> ##(fp_types_pkg::PIPE_LAT) res_valid)
        else begin
            $error("no result valid at the fixed latency after issue");
            fail_count = fail_count + 1;
        end

    a_result_from_issue: assert property (@(posedge clk) disable iff (!rstn)
        res_valid |-> $past(issue, fp_types_pkg::PIPE_LAT))
        else begin
            $error("result valid without an issue at the fixed latency");
            fail_count = fail_count + 1;
        end

endmodule

bind fp_add_top fp_add_properties i_props (
    .clk       (clk),
    .rstn      (rstn),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pslverr   (pslverr),
    .issue     (issue),
    .res_valid (res_valid)
);

//--- testbench/tb_fp_add.sv
module tb_fp_add;

    localparam int         MAX_PAT      = 64;
    localparam int         LFSR_PAIRS   = 6;
    localparam logic [4:0] OFS_UNMAPPED = 5'h14;

    logic        clk;
    logic        rstn;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [4:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    // four words per pattern: mode, a, b, expected
    logic [31:0] pat_mem [0:4*MAX_PAT-1];
    int          num_pat;
    int          checks;
    int          errors;
    int          cycle_count;
    int          cycle_limit;
    logic [31:0] lfsr_state;

    fp_add_top i_dut (
        .clk     (clk),
        .rstn    (rstn),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always #5 clk = ~clk;

    // run limit, sized from the pattern count
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("timeout: run still going after %0d cycles", cycle_limit);
            $display("*** FAILED ***");
            $finish;
        end
    end

    ////////////////////////////////////////
    // checking and reporting
    ////////////////////////////////////////
    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks = checks + 1;
        if (actual !== expected) begin
            errors = errors + 1;
            $display("FAIL t=%0t %s: got %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic report_test(input int num, input string title, input int err_before);
        if (errors == err_before) begin
            $display("test %0d %s: ok", num, title);
        end else begin
            $display("test %0d %s: %0d mismatches", num, title, errors - err_before);
        end
    endtask

    ////////////////////////////////////////
    // apb master
    ////////////////////////////////////////
    // entered and left 1 unit after a rising edge
    task automatic apb_access(input logic write, input logic [4:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #1;
        penable = 1'b1;
        // mid access phase, outputs settled
        @(negedge clk);
        rdata = prdata;
        err   = pslverr;
        check_value("pready", pready, 1);
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [4:0] addr, input logic [31:0] data, output logic err);
        logic [31:0] unused;
        apb_access(1'b1, addr, data, unused, err);
    endtask

    task automatic apb_read(input logic [4:0] addr, output logic [31:0] data, output logic err);
        apb_access(1'b0, addr, 32'h0, data, err);
    endtask

    // operands then ctrl with start
    task automatic start_op(input logic sub, input logic [31:0] a, input logic [31:0] b,
                            output logic err_any);
        logic err;
        apb_write(apb_regs_pkg::OFS_OP_A, a, err);
        err_any = err;
        apb_write(apb_regs_pkg::OFS_OP_B, b, err);
        err_any = err_any | err;
        apb_write(apb_regs_pkg::OFS_CTRL, (32'(sub) << apb_regs_pkg::CTRL_SUB)
                  | (32'd1 << apb_regs_pkg::CTRL_START), err);
        err_any = err_any | err;
    endtask

    // poll status for done, then fetch the result
    task automatic wait_result(output logic [31:0] result, output logic err_any);
        logic [31:0] status;
        logic        err;
        status  = '0;
        err_any = 1'b0;
        while (status[apb_regs_pkg::STAT_DONE] !== 1'b1) begin
            apb_read(apb_regs_pkg::OFS_STATUS, status, err);
            err_any = err_any | err;
        end
        apb_read(apb_regs_pkg::OFS_RESULT, result, err);
        err_any = err_any | err;
    endtask

    task automatic run_op(input logic sub, input logic [31:0] a, input logic [31:0] b,
                          output logic [31:0] result, output logic err_any);
        logic err;
        start_op(sub, a, b, err);
        wait_result(result, err_any);
        err_any = err_any | err;
    endtask

    ////////////////////////////////////////
    // reference model and random operands
    ////////////////////////////////////////
    // same sign normal operands, exact sum in a wide integer then truncated
    function automatic logic [31:0] model_same_sign_add(input logic [31:0] a,
                                                        input logic [31:0] b);
        logic [79:0] sum;
        logic [7:0]  e_lo;
        int          top;
        if (a[30:23] >= b[30:23]) begin
            sum  = (80'({1'b1, a[22:0]}) << (a[30:23] - b[30:23])) + 80'({1'b1, b[22:0]});
            e_lo = b[30:23];
        end else begin
            sum  = (80'({1'b1, b[22:0]}) << (b[30:23] - a[30:23])) + 80'({1'b1, a[22:0]});
            e_lo = a[30:23];
        end
        top = 0;
        for (int i = 0; i < 80; i++) begin
            if (sum[i]) begin
                top = i;
            end
        end
        // lsb weight is the last fraction bit of the smaller operand
        return {a[31], 8'(e_lo + top - 23), 23'(sum >> (top - 23))};
    endfunction

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v          = {v[30:0], fb};
        end
        return v;
    endfunction

    // exponent kept inside 100..150
    function automatic logic [31:0] random_operand();
        logic [31:0] bits;
        logic        sign;
        logic [7:0]  exp_v;
        bits  = lfsr_bits(1);
        sign  = bits[0];
        bits  = lfsr_bits(8);
        exp_v = 8'(100 + bits % 51);
        bits  = lfsr_bits(23);
        return {sign, exp_v, bits[22:0]};
    endfunction

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////
    initial begin
        logic [31:0] result;
        logic [31:0] rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] expected;
        logic        err;
        logic        err_any;
        int          err_before;

        clk         = 1'b0;
        rstn        = 1'b0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        checks      = 0;
        errors      = 0;
        cycle_count = 0;
        lfsr_state  = 32'hf8b2ae7c;

        // fill marks unused slots with an invalid mode word
        for (int i = 0; i < 4 * MAX_PAT; i++) begin
            pat_mem[i] = 32'hdead0000 ^ 32'(i);
        end
        $readmemh("testbench/fp_add_patterns.hex", pat_mem);
        num_pat = 0;
        while (num_pat < MAX_PAT && pat_mem[4*num_pat][31:1] == '0) begin
            num_pat = num_pat + 1;
        end
        cycle_limit = (num_pat + 32) * 20;

        repeat (3) @(posedge clk);
        #1;
        rstn = 1'b1;

        // 1: registers after reset
        err_before = errors;
        apb_read(apb_regs_pkg::OFS_STATUS, rd, err);
        check_value("status", rd, 32'h0);
        check_value("pslverr", err, 1'b0);
        apb_read(apb_regs_pkg::OFS_RESULT, rd, err);
        check_value("result", rd, 32'h0);
        report_test(1, "reset values", err_before);

        // 2: directed patterns from file
        err_before = errors;
        for (int i = 0; i < num_pat; i++) begin
            run_op(pat_mem[4*i][0], pat_mem[4*i+1], pat_mem[4*i+2], result, err_any);
            check_value($sformatf("pattern %0d result", i), result, pat_mem[4*i+3]);
            check_value("pslverr", err_any, 1'b0);
        end
        report_test(2, "patterns", err_before);

        // 3: busy status and start while busy, 1.0 + 2.0
        err_before = errors;
        start_op(1'b0, 32'h3f800000, 32'h40000000, err_any);
        apb_read(apb_regs_pkg::OFS_STATUS, rd, err);
        check_value("status busy", rd[apb_regs_pkg::STAT_BUSY], 1'b1);
        // a subtract here would give -1.0 if it were taken
        apb_write(apb_regs_pkg::OFS_CTRL, 32'h3, err);
        check_value("pslverr", err, 1'b0);
        wait_result(result, err);
        check_value("result", result, 32'h40400000);
        // a start taken while busy would land its result within one latency
        repeat (fp_types_pkg::PIPE_LAT + 1) @(posedge clk);
        #1;
        apb_read(apb_regs_pkg::OFS_RESULT, rd, err);
        check_value("result after latency", rd, 32'h40400000);
        report_test(3, "start while busy", err_before);

        // 4: slave errors leave the result alone
        err_before = errors;
        apb_read(OFS_UNMAPPED, rd, err);
        check_value("pslverr", err, 1'b1);
        apb_write(OFS_UNMAPPED, 32'h1, err);
        check_value("pslverr", err, 1'b1);
        apb_write(apb_regs_pkg::OFS_RESULT, 32'h12345678, err);
        check_value("pslverr", err, 1'b1);
        apb_read(apb_regs_pkg::OFS_RESULT, rd, err);
        check_value("result", rd, 32'h40400000);
        report_test(4, "slave errors", err_before);

        // 5: random pairs, commutative add and self subtract
        err_before = errors;
        for (int n = 0; n < LFSR_PAIRS; n++) begin
            a        = random_operand();
            b        = random_operand();
            b[31]    = a[31];
            expected = model_same_sign_add(a, b);
            run_op(1'b0, a, b, result, err_any);
            check_value("a+b result", result, expected);
            run_op(1'b0, b, a, result, err);
            check_value("b+a result", result, expected);
            err_any = err_any | err;
            run_op(1'b1, a, a, result, err);
            check_value("a-a result", result, 32'h0);
            check_value("pslverr", err_any | err, 1'b0);
        end
        report_test(5, "random pairs", err_before);

        // failed assertions of the bound checker
        errors = errors + i_dut.i_props.fail_count;
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- testbench/fp_add_patterns.hex
// columns: mode (0 add, 1 sub), operand a, operand b, expected result
// results truncate toward zero, denormal results flush to signed zero
00000000 3f800000 40000000 40400000
00000000 3fc00000 3fc00000 40400000
00000001 40400000 3f800000 40000000
00000001 3f800000 3f800000 00000000
00000000 3f800000 bf800000 00000000
00000001 bf800000 bf800000 00000000
00000000 80000000 80000000 80000000
00000000 3f800000 33800000 3f800000
00000000 3f800000 30800000 3f800000
00000000 30800000 40000000 40000000
00000000 3f800000 34400000 3f800001
00000000 7f7fffff 7f7fffff 7f800000
00000001 ff7fffff 7f7fffff ff800000
00000001 00c00000 00800000 00000000
00000001 00800000 00c00000 80000000
00000001 3fc00000 3fa00000 3e800000
00000000 c0800000 3f800000 c0400000
00000000 40400000 3f000000 40600000

//--- src.f
verilog/fp_types_pkg.sv
verilog/apb_regs_pkg.sv
verilog/exponent_diff.sv
verilog/mantissa_align.sv
verilog/mantissa_add_norm.sv
verilog/fp_apb_regs.sv
verilog/fp_add_top.sv
testbench/fp_add_properties.sv
testbench/tb_fp_add.sv

//--- Makefile
# verilator flow for the fp32 adder, run from the project root

VERILATOR  ?= verilator
TOP        ?= tb_fp_add
FILELIST   ?= src.f
BUILD_DIR  ?= obj_dir
PASS_MSG   ?= *** PASSED ***
VFLAGS     ?= --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# pass only when the pass line shows up in the output
sim: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
